// ==== Makefile ====
TOP := tb_cpu_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== design/axi_lite_pkg.sv ====
// ========================================
// AXI4-Lite bus definitions
// response codes and the RAM word layout
// ========================================
package axi_lite_pkg;

    // bus word geometry
    localparam int axi_word_bytes = 4;
    localparam int axi_word_bits = axi_word_bytes * 8;

    // xRESP encodings used on r and b
    localparam logic [1:0] axi_resp_okay = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // one RAM entry, seen as a whole word on reads
    // and as byte lanes for strobed writes
    typedef union packed {
        logic [axi_word_bits-1:0] word;
        logic [axi_word_bytes-1:0][7:0] lane;
    } ram_word_t;

endpackage

// ==== design/axi_lite_ram.sv ====
// ========================================
// AXI4-Lite RAM slave with byte strobes
// SLVERR beyond mem_words
// ========================================
`timescale 1ns/1ps

module axi_lite_ram import axi_lite_pkg::*; #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int mem_words = 256
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    arvalid,
    output logic                    arready,
    input  logic [addr_width-1:0]   araddr,

    input  logic                    awvalid,
    output logic                    awready,
    input  logic [addr_width-1:0]   awaddr,

    input  logic                    wvalid,
    output logic                    wready,
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wstrb,

    output logic                    rvalid,
    input  logic                    rready,
    output logic [data_width-1:0]   rdata,
    output logic [1:0]              rresp,

    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp
);

    localparam int off_bits = $clog2(data_width / 8);
    localparam int idx_bits = $clog2(mem_words);

    typedef enum logic {
        resp_idle,
        resp_hold
    } resp_state_t;

    ram_word_t mem [mem_words];

    resp_state_t                   resp_state;
    logic                          resp_read;
    logic [1:0]                    resp_code;
    logic [data_width-1:0]         rdata_q;
    logic [addr_width-off_bits-1:0] rd_word;
    logic [addr_width-off_bits-1:0] wr_word;
    logic                          rd_in_range;
    logic                          wr_in_range;
    logic                          rd_take;
    logic                          wr_take;

    assign rd_word = araddr[addr_width-1:off_bits];
    assign wr_word = awaddr[addr_width-1:off_bits];
    assign rd_in_range = (rd_word < mem_words);
    assign wr_in_range = (wr_word < mem_words);

    // reads win when both address channels are valid
    assign arready = (resp_state == resp_idle);
    assign awready = (resp_state == resp_idle) && !arvalid;
    assign wready = (resp_state == resp_idle) && !arvalid;

    assign rd_take = arvalid && arready;
    assign wr_take = awvalid && wvalid && awready && wready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            resp_state <= resp_idle;
            resp_read <= 1'b0;
            resp_code <= axi_resp_okay;
        end else if (resp_state == resp_idle) begin
            if (rd_take) begin
                resp_state <= resp_hold;
                resp_read <= 1'b1;
                resp_code <= rd_in_range ? axi_resp_okay : axi_resp_slverr;
            end else if (wr_take) begin
                resp_state <= resp_hold;
                resp_read <= 1'b0;
                resp_code <= wr_in_range ? axi_resp_okay : axi_resp_slverr;
            end
        end else if ((rvalid && rready) || (bvalid && bready)) begin
            resp_state <= resp_idle;
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata_q <= rd_in_range ? mem[rd_word[idx_bits-1:0]].word : '0;
        end
        if (!rd_take && wr_take && wr_in_range) begin
            for (int i = 0; i < data_width / 8; i++) begin
                if (wstrb[i]) begin
                    mem[wr_word[idx_bits-1:0]].lane[i] <= wdata[8*i +: 8];
                end
            end
        end
    end

    assign rvalid = (resp_state == resp_hold) && resp_read;
    assign bvalid = (resp_state == resp_hold) && !resp_read;
    assign rdata = rdata_q;
    assign rresp = resp_code;
    assign bresp = resp_code;

endmodule

// ==== design/cpu_bus_top.sv ====
// ========================================
// two processor ports onto one AXI4-Lite
// bus with a RAM slave
// ========================================
`timescale 1ns/1ps

module cpu_bus_top #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int mem_words = 256
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    inst_ce,
    input  logic                    inst_we,
    input  logic [addr_width-1:0]   inst_addr,
    input  logic [data_width-1:0]   inst_wdata,
    input  logic [data_width/8-1:0] inst_wmask,
    output logic [data_width-1:0]   inst_rdata,
    output logic                    inst_rdata_valid,
    output logic                    inst_write_finish,
    output logic                    inst_error,

    input  logic                    data_ce,
    input  logic                    data_we,
    input  logic [addr_width-1:0]   data_addr,
    input  logic [data_width-1:0]   data_wdata,
    input  logic [data_width/8-1:0] data_wmask,
    output logic [data_width-1:0]   data_rdata,
    output logic                    data_rdata_valid,
    output logic                    data_write_finish,
    output logic                    data_error
);

    // granted request
    logic                    req;
    logic                    we;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   wdata;
    logic [data_width/8-1:0] wmask;
    logic                    done;
    logic [data_width-1:0]   rdata;
    logic                    error;

    // AXI4-Lite channels
    logic                    arvalid;
    logic                    arready;
    logic [addr_width-1:0]   araddr;
    logic                    awvalid;
    logic                    awready;
    logic [addr_width-1:0]   awaddr;
    logic                    wvalid;
    logic                    wready;
    logic [data_width-1:0]   wdata_bus;
    logic [data_width/8-1:0] wstrb;
    logic                    rvalid;
    logic                    rready;
    logic [data_width-1:0]   rdata_bus;
    logic [1:0]              rresp;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;

    sram_port_arbiter #(
        .addr_width (addr_width),
        .data_width (data_width)
    ) u_arbiter (
        .clk               (clk),
        .reset             (reset),
        .inst_ce           (inst_ce),
        .inst_we           (inst_we),
        .inst_addr         (inst_addr),
        .inst_wdata        (inst_wdata),
        .inst_wmask        (inst_wmask),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .inst_write_finish (inst_write_finish),
        .inst_error        (inst_error),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .data_error        (data_error),
        .req               (req),
        .we                (we),
        .addr              (addr),
        .wdata             (wdata),
        .wmask             (wmask),
        .done              (done),
        .rdata             (rdata),
        .error             (error)
    );

    sram_to_axi_lite #(
        .addr_width (addr_width),
        .data_width (data_width)
    ) u_bridge (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .wmask     (wmask),
        .done      (done),
        .rdata     (rdata),
        .error     (error),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata_bus (wdata_bus),
        .wstrb     (wstrb),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata_bus (rdata_bus),
        .rresp     (rresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp)
    );

    axi_lite_ram #(
        .addr_width (addr_width),
        .data_width (data_width),
        .mem_words  (mem_words)
    ) u_ram (
        .clk     (clk),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata_bus),
        .wstrb   (wstrb),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata_bus),
        .rresp   (rresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp)
    );

endmodule

// ==== design/sram_port_arbiter.sv ====
// ========================================
// fixed-priority arbiter, data over inst
// grant held until the transfer completes
// ========================================
`timescale 1ns/1ps

module sram_port_arbiter import sram_port_pkg::*; #(
    parameter int addr_width = 32,
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,

    // instruction port
    input  logic                    inst_ce,
    input  logic                    inst_we,
    input  logic [addr_width-1:0]   inst_addr,
    input  logic [data_width-1:0]   inst_wdata,
    input  logic [data_width/8-1:0] inst_wmask,
    output logic [data_width-1:0]   inst_rdata,
    output logic                    inst_rdata_valid,
    output logic                    inst_write_finish,
    output logic                    inst_error,

    // data port
    input  logic                    data_ce,
    input  logic                    data_we,
    input  logic [addr_width-1:0]   data_addr,
    input  logic [data_width-1:0]   data_wdata,
    input  logic [data_width/8-1:0] data_wmask,
    output logic [data_width-1:0]   data_rdata,
    output logic                    data_rdata_valid,
    output logic                    data_write_finish,
    output logic                    data_error,

    // single request towards the bridge
    output logic                    req,
    output logic                    we,
    output logic [addr_width-1:0]   addr,
    output logic [data_width-1:0]   wdata,
    output logic [data_width/8-1:0] wmask,
    input  logic                    done,
    input  logic [data_width-1:0]   rdata,
    input  logic                    error
);

    logic       busy;
    requester_t owner;
    sram_kind_t kind;
    logic       done_data;
    logic       done_inst;

    // grant only from an idle cycle, release on done
    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
            owner <= req_data;
        end else if (!busy) begin
            if (data_ce) begin
                busy <= 1'b1;
                owner <= req_data;
            end else if (inst_ce) begin
                busy <= 1'b1;
                owner <= req_inst;
            end
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // owner's request onto the shared port
    assign req = busy;
    assign we = (owner == req_data) ? data_we : inst_we;
    assign addr = (owner == req_data) ? data_addr : inst_addr;
    assign wdata = (owner == req_data) ? data_wdata : inst_wdata;
    assign wmask = (owner == req_data) ? data_wmask : inst_wmask;

    // owner holds we steady, so it still names the kind at done
    assign kind = we ? sram_write : sram_read;

    assign done_data = done && (owner == req_data);
    assign done_inst = done && (owner == req_inst);

    // completion steering
    assign data_rdata = rdata;
    assign data_rdata_valid = done_data && (kind == sram_read);
    assign data_write_finish = done_data && (kind == sram_write);
    assign data_error = done_data && error;

    assign inst_rdata = rdata;
    assign inst_rdata_valid = done_inst && (kind == sram_read);
    assign inst_write_finish = done_inst && (kind == sram_write);
    assign inst_error = done_inst && error;

endmodule

// ==== design/sram_port_pkg.sv ====
// ========================================
// SRAM-style requester definitions
// ========================================
package sram_port_pkg;

    // which processor port holds the bus
    typedef enum logic {
        req_data = 1'b0,
        req_inst = 1'b1
    } requester_t;

    // request kind, follows the we level
    typedef enum logic {
        sram_read = 1'b0,
        sram_write = 1'b1
    } sram_kind_t;

endpackage

// ==== design/sram_to_axi_lite.sv ====
// ========================================
// SRAM-style request to AXI4-Lite bridge
// one transfer in flight at a time
// ========================================
`timescale 1ns/1ps

module sram_to_axi_lite import axi_lite_pkg::*; #(
    parameter int addr_width = 32,
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,

    // request side
    input  logic                    req,
    input  logic                    we,
    input  logic [addr_width-1:0]   addr,
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wmask,
    output logic                    done,
    output logic [data_width-1:0]   rdata,
    output logic                    error,

    // read address
    output logic                    arvalid,
    input  logic                    arready,
    output logic [addr_width-1:0]   araddr,

    // write address
    output logic                    awvalid,
    input  logic                    awready,
    output logic [addr_width-1:0]   awaddr,

    // write data
    output logic                    wvalid,
    input  logic                    wready,
    output logic [data_width-1:0]   wdata_bus,
    output logic [data_width/8-1:0] wstrb,

    // read data
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [data_width-1:0]   rdata_bus,
    input  logic [1:0]              rresp,

    // write response
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [1:0]              bresp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_rresp,
        st_bresp
    } state_t;

    state_t state;
    logic   r_fire;
    logic   b_fire;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        // aw and w launch in the same cycle
                        if (we) begin
                            awvalid <= 1'b1;
                            wvalid <= 1'b1;
                        end else begin
                            arvalid <= 1'b1;
                        end
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            state <= st_rresp;
                        end
                    end else begin
                        // each write channel drops on its own handshake
                        if (awvalid && awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wvalid && wready) begin
                            wvalid <= 1'b0;
                        end
                        if ((!awvalid || awready) && (!wvalid || wready)) begin
                            state <= st_bresp;
                        end
                    end
                end
                st_rresp: begin
                    if (r_fire) begin
                        state <= st_idle;
                    end
                end
                st_bresp: begin
                    if (b_fire) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // channel payload, captured at launch
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            araddr <= addr;
            awaddr <= addr;
            wdata_bus <= wdata;
            wstrb <= wmask;
        end
    end

    assign rready = (state == st_rresp);
    assign bready = (state == st_bresp);

    assign r_fire = rready && rvalid;
    assign b_fire = bready && bvalid;

    // completion back to the arbiter
    assign done = r_fire || b_fire;
    assign error = (r_fire && rresp != axi_resp_okay)
                || (b_fire && bresp != axi_resp_okay);
    assign rdata = (rresp == axi_resp_okay) ? rdata_bus : '0;

endmodule

// ==== project.f ====
design/axi_lite_pkg.sv
design/sram_port_pkg.sv
design/sram_port_arbiter.sv
design/sram_to_axi_lite.sv
design/axi_lite_ram.sv
design/cpu_bus_top.sv
test/cpu_bus_assertions.sv
test/tb_cpu_bus.sv

// ==== test/cpu_bus_assertions.sv ====
// ========================================
// AXI4-Lite channel and request checks
// bound into the bridge
// ========================================
`timescale 1ns/1ps

module cpu_bus_assertions #(
    parameter int addr_width = 32,
    parameter int data_width = 32
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    req,
    input logic                    done,
    input logic                    arvalid,
    input logic                    arready,
    input logic [addr_width-1:0]   araddr,
    input logic                    awvalid,
    input logic                    awready,
    input logic [addr_width-1:0]   awaddr,
    input logic                    wvalid,
    input logic                    wready,
    input logic [data_width-1:0]   wdata_bus,
    input logic [data_width/8-1:0] wstrb
);

    // valid and payload hold until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    w_hold: assert property (@(posedge clk) disable iff (!reset)
        wvalid && !wready |=> wvalid && $stable(wdata_bus) && $stable(wstrb))
        else $error("wvalid dropped or write data moved before wready");

    aw_w_together: assert property (@(posedge clk) disable iff (!reset)
        $rose(awvalid) == $rose(wvalid))
        else $error("awvalid and wvalid did not rise together");

    done_pulse: assert property (@(posedge clk) disable iff (!reset)
        done |=> !done)
        else $error("done longer than one cycle");

    // arbiter keeps the grant until done
    req_hold: assert property (@(posedge clk) disable iff (!reset)
        req && !done |=> req)
        else $error("req dropped before done");

endmodule

bind sram_to_axi_lite cpu_bus_assertions #(
    .addr_width (addr_width),
    .data_width (data_width)
) u_assertions (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .done      (done),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata_bus (wdata_bus),
    .wstrb     (wstrb)
);

// ==== test/tb_cpu_bus.sv ====
// ========================================
// testbench for the two-port AXI4-Lite bus
// random traffic checked against a model
// ========================================
`timescale 1ns/1ps

module tb_cpu_bus;

    localparam int mem_words = 256;
    localparam int random_txns = 400;
    localparam int directed_txns = mem_words + 4;
    localparam int cycle_limit = (random_txns + directed_txns) * 20;

    logic        clk;
    logic        reset;
    logic        inst_ce;
    logic        inst_we;
    logic [31:0] inst_addr;
    logic [31:0] inst_wdata;
    logic [3:0]  inst_wmask;
    logic [31:0] inst_rdata;
    logic        inst_rdata_valid;
    logic        inst_write_finish;
    logic        inst_error;
    logic        data_ce;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_wmask;
    logic [31:0] data_rdata;
    logic        data_rdata_valid;
    logic        data_write_finish;
    logic        data_error;

    // reference memory and per-port request record, index 0 data, 1 inst
    logic [31:0] model [mem_words];
    logic [31:0] rng_state;
    int          cycles;
    int          completions;
    int          issued;
    bit          act [2];
    bit          finished [2];
    bit          check_lat [2];
    bit          p_we [2];
    logic [31:0] p_addr [2];
    logic [31:0] p_wdata [2];
    logic [3:0]  p_mask [2];
    int          p_start [2];
    int          p_end [2];

    cpu_bus_top #(
        .addr_width (32),
        .data_width (32),
        .mem_words  (mem_words)
    ) dut (
        .clk               (clk),
        .reset             (reset),
        .inst_ce           (inst_ce),
        .inst_we           (inst_we),
        .inst_addr         (inst_addr),
        .inst_wdata        (inst_wdata),
        .inst_wmask        (inst_wmask),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .inst_write_finish (inst_write_finish),
        .inst_error        (inst_error),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .data_error        (data_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ 32'(idx);
    endfunction

    function automatic string port_name(input int p);
        return (p == 0) ? "data" : "inst";
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail at %0t: %s, got %h expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic drive_port(input int p, input bit ce, input bit we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] mask);
        if (p == 0) begin
            data_ce <= ce;
            data_we <= we;
            data_addr <= addr;
            data_wdata <= wdata;
            data_wmask <= mask;
        end else begin
            inst_ce <= ce;
            inst_we <= we;
            inst_addr <= addr;
            inst_wdata <= wdata;
            inst_wmask <= mask;
        end
    endtask

    task automatic start_request(input int p, input bit we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] mask,
                                 input bit lat);
        act[p] = 1'b1;
        finished[p] = 1'b0;
        check_lat[p] = lat;
        p_we[p] = we;
        p_addr[p] = addr;
        p_wdata[p] = wdata;
        p_mask[p] = mask;
        p_start[p] = cycles;
        drive_port(p, 1'b1, we, addr, wdata, mask);
    endtask

    // drop ce on ports whose pulse came in the last cycle
    task automatic retire_finished();
        for (int p = 0; p < 2; p++) begin
            if (finished[p]) begin
                finished[p] = 1'b0;
                act[p] = 1'b0;
                drive_port(p, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
            end
        end
    endtask

    task automatic wait_all_idle();
        while (act[0] || act[1]) begin
            @(posedge clk);
            retire_finished();
        end
    endtask

    task automatic random_request(input int p);
        logic [31:0] r;
        logic [31:0] a;
        int          word;
        r = next_rand();
        a = next_rand();
        // about one in eight beyond the RAM
        if (a[2:0] == 3'd0) begin
            word = mem_words + int'(a[12:3]);
        end else begin
            word = int'(a[31:3] % mem_words);
        end
        start_request(p, r[0], 32'(word) << 2, next_rand(), r[7:4], 1'b0);
        issued++;
    endtask

    task automatic check_port(input int p, input logic rv, input logic wf, input logic er,
                              input logic [31:0] rd);
        int   idx;
        logic in_range;
        if (rv || wf || er) begin
            if (!act[p] || finished[p]) begin
                abort_run($sformatf("%s port gave a completion pulse with no request pending",
                                    port_name(p)));
            end else begin
                idx = int'(p_addr[p] >> 2);
                in_range = (idx < mem_words);
                check_value({port_name(p), " write_finish"}, 32'(wf), 32'(p_we[p]));
                check_value({port_name(p), " rdata_valid"}, 32'(rv), 32'(!p_we[p]));
                check_value({port_name(p), " error"}, 32'(er), 32'(!in_range));
                if (!p_we[p]) begin
                    check_value({port_name(p), " rdata"}, rd, in_range ? model[idx] : 32'h0);
                end else if (in_range) begin
                    for (int b = 0; b < 4; b++) begin
                        if (p_mask[p][b]) begin
                            model[idx][8*b +: 8] = p_wdata[p][8*b +: 8];
                        end
                    end
                end
                if (check_lat[p]) begin
                    check_value({port_name(p), " latency"}, 32'(cycles - p_start[p]), 32'd3);
                end
                p_end[p] = cycles;
                finished[p] = 1'b1;
                completions++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        check_value("completion pulses on both ports in one cycle",
                    32'((data_rdata_valid || data_write_finish || data_error)
                        && (inst_rdata_valid || inst_write_finish || inst_error)), 32'h0);
        check_port(0, data_rdata_valid, data_write_finish, data_error, data_rdata);
        check_port(1, inst_rdata_valid, inst_write_finish, inst_error, inst_rdata);
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        logic [31:0] r;
        int          base;
        rng_state = 32'd96623;
        cycles = 0;
        completions = 0;
        issued = 0;
        for (int p = 0; p < 2; p++) begin
            act[p] = 1'b0;
            finished[p] = 1'b0;
            check_lat[p] = 1'b0;
        end
        reset = 1'b0;
        inst_ce = 1'b0;
        inst_we = 1'b0;
        inst_addr = 32'h0;
        inst_wdata = 32'h0;
        inst_wmask = 4'h0;
        data_ce = 1'b0;
        data_we = 1'b0;
        data_addr = 32'h0;
        data_wdata = 32'h0;
        data_wmask = 4'h0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        // idle cycles, any pulse here is caught by the monitor
        repeat (5) @(posedge clk);

        // fill every word, alternating ports, each on an idle system
        for (int i = 0; i < mem_words; i++) begin
            start_request(i % 2, 1'b1, 32'(i) << 2, fill_word(i), 4'hf, 1'b1);
            wait_all_idle();
        end

        // beyond the RAM on both ports
        start_request(0, 1'b0, 32'(mem_words) << 2, 32'h0, 4'h0, 1'b1);
        wait_all_idle();
        start_request(1, 1'b1, 32'hffff_fff0, 32'hdead_beef, 4'hf, 1'b1);
        wait_all_idle();

        // both ports at once, data wins and inst reads its result
        start_request(0, 1'b1, 32'd17 << 2, 32'h1234_5678, 4'b0101, 1'b1);
        start_request(1, 1'b0, 32'd17 << 2, 32'h0, 4'h0, 1'b0);
        wait_all_idle();
        check_value("data port completes before inst port", 32'(p_end[0] < p_end[1]), 32'd1);

        // random traffic until every random transfer has completed
        base = completions;
        while (completions - base < random_txns) begin
            @(posedge clk);
            retire_finished();
            for (int p = 0; p < 2; p++) begin
                r = next_rand();
                if (!act[p] && issued < random_txns && r[1:0] != 2'd0) begin
                    random_request(p);
                end
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule
